//--- logic/anneal_pkg.sv
package anneal_pkg;

    localparam int CITY_NUM = 16;
    localparam int POS_W    = 4;
    localparam int COORD_W  = 8;
    localparam int DIST_W   = 10;
    localparam int DELTA_W  = 12;
    localparam int TEMP_W   = 8;
    localparam int COUNT_W  = 16;

    typedef logic [POS_W-1:0]          pos_t;
    typedef logic [POS_W-1:0]          city_t;
    typedef logic [COORD_W-1:0]        coord_t;
    typedef logic [DIST_W-1:0]         dist_t;
    typedef logic signed [DELTA_W-1:0] delta_t;
    typedef logic [TEMP_W-1:0]         temp_t;
    typedef logic [31:0]               rword_t;
    typedef logic [63:0]               seed_t;
    typedef logic [COUNT_W-1:0]        count_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } xy_t;

    // Segment k..l of the tour, k < l
    typedef struct packed {
        pos_t   k;
        pos_t   l;
        rword_t r_metropolis;
        rword_t r_exchange;
    } move_t;

    typedef struct packed {
        move_t  move;
        delta_t delta;
        logic   accepted;
    } report_t;

endpackage

//--- logic/anneal_top.sv
module anneal_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  anneal_pkg::seed_t   seed,
    input  anneal_pkg::temp_t   temp,
    input  anneal_pkg::count_t  move_count,
    input  logic                coord_we,
    input  anneal_pkg::city_t   coord_addr,
    input  anneal_pkg::xy_t     coord_data,
    input  anneal_pkg::pos_t    rd_pos,
    output anneal_pkg::city_t   rd_city,
    output logic                report_valid,
    output anneal_pkg::report_t report,
    output logic                busy,
    output logic                done
);
    import anneal_pkg::*;

    logic   run_start;
    logic   move_valid;
    move_t  move;
    city_t  city_a;
    city_t  city_b;
    city_t  city_c;
    city_t  city_d;
    logic   eval_valid;
    move_t  eval_move;
    delta_t delta;
    logic   credit_return;
    temp_t  temp_l;
    count_t count_l;
    count_t moves_done;
    count_t moves_next;

    assign run_start  = start && !busy;
    assign moves_next = moves_done + count_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            moves_done <= '0;
        end else begin
            done <= 1'b0;
            if (run_start) begin
                moves_done <= '0;
                if (move_count == '0)
                    done <= 1'b1;
                else
                    busy <= 1'b1;
            end else if (busy && credit_return) begin
                moves_done <= moves_next;
                if (moves_next == count_l) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run_start) begin
            temp_l  <= temp;
            count_l <= move_count;
        end
    end

    move_rand u_move_rand (
        .clk           (clk),
        .reset         (reset),
        .start         (run_start),
        .seed          (seed),
        .run           (busy),
        .credit_return (credit_return),
        .move_valid    (move_valid),
        .move          (move)
    );

    // Coordinates only change between runs
    tour_delta u_tour_delta (
        .clk        (clk),
        .reset      (reset),
        .coord_we   (coord_we && !busy),
        .coord_addr (coord_addr),
        .coord_data (coord_data),
        .move_valid (move_valid),
        .move       (move),
        .city_a     (city_a),
        .city_b     (city_b),
        .city_c     (city_c),
        .city_d     (city_d),
        .eval_valid (eval_valid),
        .eval_move  (eval_move),
        .delta      (delta)
    );

    metropolis_accept u_accept (
        .clk          (clk),
        .reset        (reset),
        .temp         (temp_l),
        .eval_valid   (eval_valid),
        .eval_move    (eval_move),
        .delta        (delta),
        .report_valid (report_valid),
        .report       (report)
    );

    tour_store u_tour_store (
        .clk           (clk),
        .reset         (reset),
        .move          (move),
        .report_valid  (report_valid),
        .report        (report),
        .city_a        (city_a),
        .city_b        (city_b),
        .city_c        (city_c),
        .city_d        (city_d),
        .rd_pos        (rd_pos),
        .rd_city       (rd_city),
        .credit_return (credit_return)
    );

    assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

//--- logic/metropolis_accept.sv
module metropolis_accept (
    input  logic                clk,
    input  logic                reset,
    input  anneal_pkg::temp_t   temp,
    input  logic                eval_valid,
    input  anneal_pkg::move_t   eval_move,
    input  anneal_pkg::delta_t  delta,
    output logic                report_valid,
    output anneal_pkg::report_t report
);
    import anneal_pkg::*;

    logic [2*TEMP_W-1:0] prod;
    delta_t              thresh;
    logic                accept;

    // Uphill budget scaled by the random byte
    assign prod   = temp * eval_move.r_metropolis[TEMP_W-1:0];
    assign thresh = delta_t'(prod[2*TEMP_W-1:TEMP_W]);
    assign accept = (delta <= delta_t'(0)) || (delta < thresh);

    always_ff @(posedge clk) begin
        if (reset)
            report_valid <= 1'b0;
        else
            report_valid <= eval_valid;
    end

    always_ff @(posedge clk) begin
        if (eval_valid)
            report <= '{move: eval_move, delta: delta, accepted: accept};
    end

endmodule

//--- logic/move_rand.sv
module move_rand (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  anneal_pkg::seed_t seed,
    input  logic              run,
    input  logic              credit_return,
    output logic              move_valid,
    output anneal_pkg::move_t move
);
    import anneal_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        DRAW_K,
        DRAW_L,
        DRAW_METRO,
        DRAW_EXCH,
        WAIT_CREDIT
    } gen_state_t;

    gen_state_t fsm;
    logic       credit_cnt;
    seed_t      rng_q;
    seed_t      rng_next;
    seed_t      x1;
    seed_t      x2;
    pos_t       draw_pos;
    rword_t     draw_word;
    pos_t       first_pos;
    logic       drawing;

    // xorshift64 step
    always_comb begin
        x1       = rng_q ^ (rng_q << 13);
        x2       = x1 ^ (x1 >> 7);
        rng_next = x2 ^ (x2 << 17);
    end

    assign draw_pos  = rng_next[POS_W-1:0];
    assign draw_word = rng_next[31:0];
    assign drawing   = run && (fsm inside {DRAW_K, DRAW_L, DRAW_METRO, DRAW_EXCH});

    always_ff @(posedge clk) begin
        if (reset) begin
            fsm        <= IDLE;
            move_valid <= 1'b0;
            credit_cnt <= 1'b1;
        end else begin
            move_valid <= 1'b0;
            if (credit_return)
                credit_cnt <= 1'b1;
            case (fsm)
                IDLE: if (start && credit_cnt) fsm <= DRAW_K;
                DRAW_K: begin
                    if (!run)
                        fsm <= IDLE;
                    else if (draw_pos != '0)
                        fsm <= DRAW_L;
                end
                DRAW_L: begin
                    if (!run)
                        fsm <= IDLE;
                    // Equal positions restart the pair
                    else if (draw_pos != '0)
                        fsm <= (draw_pos == first_pos) ? DRAW_K : DRAW_METRO;
                end
                DRAW_METRO: fsm <= run ? DRAW_EXCH : IDLE;
                DRAW_EXCH: begin
                    if (!run) begin
                        fsm <= IDLE;
                    end else begin
                        move_valid <= 1'b1;
                        credit_cnt <= 1'b0;
                        fsm        <= WAIT_CREDIT;
                    end
                end
                WAIT_CREDIT: if (credit_return) fsm <= run ? DRAW_K : IDLE;
                default: fsm <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fsm == IDLE && start)
            rng_q <= seed;
        else if (drawing)
            rng_q <= rng_next;

        if (drawing) begin
            case (fsm)
                DRAW_K: if (draw_pos != '0) first_pos <= draw_pos;
                DRAW_L: begin
                    if (draw_pos != '0 && draw_pos != first_pos) begin
                        move.k <= (draw_pos < first_pos) ? draw_pos : first_pos;
                        move.l <= (draw_pos < first_pos) ? first_pos : draw_pos;
                    end
                end
                DRAW_METRO: move.r_metropolis <= draw_word;
                DRAW_EXCH:  move.r_exchange   <= draw_word;
                default: ;
            endcase
        end
    end

    // A credit comes back only for a move that was sent
    assert property (@(posedge clk) disable iff (reset) credit_return |-> !credit_cnt);
    assert property (@(posedge clk) disable iff (reset) move_valid |-> move.k < move.l);

endmodule

//--- logic/tour_delta.sv
module tour_delta (
    input  logic               clk,
    input  logic               reset,
    input  logic               coord_we,
    input  anneal_pkg::city_t  coord_addr,
    input  anneal_pkg::xy_t    coord_data,
    input  logic               move_valid,
    input  anneal_pkg::move_t  move,
    input  anneal_pkg::city_t  city_a,
    input  anneal_pkg::city_t  city_b,
    input  anneal_pkg::city_t  city_c,
    input  anneal_pkg::city_t  city_d,
    output logic               eval_valid,
    output anneal_pkg::move_t  eval_move,
    output anneal_pkg::delta_t delta
);
    import anneal_pkg::*;

    xy_t    coord_mem [CITY_NUM];
    dist_t  d_ab;
    dist_t  d_cd;
    dist_t  d_ac;
    dist_t  d_bd;
    delta_t new_len;
    delta_t old_len;

    function automatic dist_t manhattan(xy_t p, xy_t q);
        coord_t dx;
        coord_t dy;
        dx = (p.x > q.x) ? p.x - q.x : q.x - p.x;
        dy = (p.y > q.y) ? p.y - q.y : q.y - p.y;
        return dist_t'(dx) + dist_t'(dy);
    endfunction

    always_ff @(posedge clk) begin
        if (coord_we)
            coord_mem[coord_addr] <= coord_data;
    end

    // Old edges a-b and c-d, new edges a-c and b-d
    assign d_ab = manhattan(coord_mem[city_a], coord_mem[city_b]);
    assign d_cd = manhattan(coord_mem[city_c], coord_mem[city_d]);
    assign d_ac = manhattan(coord_mem[city_a], coord_mem[city_c]);
    assign d_bd = manhattan(coord_mem[city_b], coord_mem[city_d]);

    assign new_len = delta_t'(d_ac) + delta_t'(d_bd);
    assign old_len = delta_t'(d_ab) + delta_t'(d_cd);

    always_ff @(posedge clk) begin
        if (reset)
            eval_valid <= 1'b0;
        else
            eval_valid <= move_valid;
    end

    always_ff @(posedge clk) begin
        if (move_valid) begin
            eval_move <= move;
            delta     <= new_len - old_len;
        end
    end

endmodule

//--- logic/tour_store.sv
module tour_store (
    input  logic                clk,
    input  logic                reset,
    input  anneal_pkg::move_t   move,
    input  logic                report_valid,
    input  anneal_pkg::report_t report,
    output anneal_pkg::city_t   city_a,
    output anneal_pkg::city_t   city_b,
    output anneal_pkg::city_t   city_c,
    output anneal_pkg::city_t   city_d,
    input  anneal_pkg::pos_t    rd_pos,
    output anneal_pkg::city_t   rd_city,
    output logic                credit_return
);
    import anneal_pkg::*;

    typedef enum logic {
        IDLE,
        SWAP
    } swap_state_t;

    swap_state_t fsm;
    city_t       tour [CITY_NUM];
    pos_t        lo;
    pos_t        hi;
    pos_t        gap;
    pos_t        pos_prev;
    pos_t        pos_next;

    // Neighbors of the segment ends, wrapping modulo the city count
    assign pos_prev = move.k - pos_t'(1);
    assign pos_next = move.l + pos_t'(1);

    assign city_a  = tour[pos_prev];
    assign city_b  = tour[move.k];
    assign city_c  = tour[move.l];
    assign city_d  = tour[pos_next];
    assign rd_city = tour[rd_pos];

    assign gap = hi - lo;

    always_ff @(posedge clk) begin
        if (reset) begin
            fsm           <= IDLE;
            credit_return <= 1'b0;
            lo            <= '0;
            hi            <= '0;
            for (int i = 0; i < CITY_NUM; i++)
                tour[i] <= city_t'(i);
        end else begin
            credit_return <= 1'b0;
            case (fsm)
                IDLE: begin
                    if (report_valid) begin
                        if (report.accepted) begin
                            lo  <= report.move.k;
                            hi  <= report.move.l;
                            fsm <= SWAP;
                        end else begin
                            credit_return <= 1'b1;
                        end
                    end
                end
                SWAP: begin
                    tour[lo] <= tour[hi];
                    tour[hi] <= tour[lo];
                    lo       <= lo + pos_t'(1);
                    hi       <= hi - pos_t'(1);
                    // Ends meet or cross after this swap
                    if (gap <= pos_t'(2)) begin
                        fsm           <= IDLE;
                        credit_return <= 1'b1;
                    end
                end
                default: fsm <= IDLE;
            endcase
        end
    end

    // Moves never start at position 0, so the home city stays put
    assert property (@(posedge clk) disable iff (reset) tour[0] == '0);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the annealer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module anneal_tb -o anneal_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/anneal_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- sim.f
logic/anneal_pkg.sv
logic/move_rand.sv
logic/tour_store.sv
logic/tour_delta.sv
logic/metropolis_accept.sv
logic/anneal_top.sv
test/anneal_tb.sv

//--- test/anneal_stimulus.txt
// Line 1: run count. Next 16 words: city 0..15 coordinates as xxyy hex.
// Then one line per run: seed (64-bit hex), temperature, move count.
3
1020 8030 4a70 c010
f05a 2ec8 90e0 35f2
d4a6 6b18 0f90 a73c
58b4 e8ee 1c60 7e7e
// Run 1 at temperature 0
0123456789abcdef 00 000c
// Run 2 continues from the tour left by run 1
5a17c3e90b2d4f61 28 0018
// Run 3 at a high temperature
9e3779b97f4a7c15 c8 0010

//--- test/anneal_tb.sv
module anneal_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import anneal_pkg::*;

    localparam int STIM_WORDS = 64;
    localparam int RUN_BASE   = 1 + CITY_NUM;

    logic    clk;
    logic    reset;
    logic    start;
    seed_t   seed;
    temp_t   temp;
    count_t  move_count;
    logic    coord_we;
    city_t   coord_addr;
    xy_t     coord_data;
    pos_t    rd_pos;
    city_t   rd_city;
    logic    report_valid;
    report_t report;
    logic    busy;
    logic    done;

    logic [63:0] stim [0:STIM_WORDS-1];
    xy_t         coords [CITY_NUM];
    int          tour_model [CITY_NUM];
    seed_t       rng;
    int          num_runs;
    int          checks;
    int          errors;
    int          reports_total;
    int          cycle_count;
    int          cycle_limit;

    anneal_top DUT (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .seed         (seed),
        .temp         (temp),
        .move_count   (move_count),
        .coord_we     (coord_we),
        .coord_addr   (coord_addr),
        .coord_data   (coord_data),
        .rd_pos       (rd_pos),
        .rd_city      (rd_city),
        .report_valid (report_valid),
        .report       (report),
        .busy         (busy),
        .done         (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    function automatic seed_t xorshift(input seed_t s);
        seed_t v;
        v = s ^ (s << 13);
        v = v ^ (v >> 7);
        v = v ^ (v << 17);
        return v;
    endfunction

    function automatic int dist_between(input int ca, input int cb);
        int dx;
        int dy;
        dx = int'(coords[ca].x) - int'(coords[cb].x);
        dy = int'(coords[ca].y) - int'(coords[cb].y);
        if (dx < 0)
            dx = -dx;
        if (dy < 0)
            dy = -dy;
        return dx + dy;
    endfunction

    // Draw order K, L, Metropolis word, exchange word
    task automatic next_model_move(output pos_t k, output pos_t l,
                                   output rword_t rm, output rword_t rx);
        pos_t first;
        pos_t second;
        logic got_pair;
        got_pair = 1'b0;
        while (!got_pair) begin
            first = '0;
            while (first == '0) begin
                rng   = xorshift(rng);
                first = rng[POS_W-1:0];
            end
            second = '0;
            while (second == '0) begin
                rng    = xorshift(rng);
                second = rng[POS_W-1:0];
            end
            got_pair = (second != first);
        end
        k   = (first < second) ? first : second;
        l   = (first < second) ? second : first;
        rng = xorshift(rng);
        rm  = rng[31:0];
        rng = xorshift(rng);
        rx  = rng[31:0];
    endtask

    task automatic check_report(input int t);
        pos_t   k;
        pos_t   l;
        rword_t rm;
        rword_t rx;
        int     a;
        int     b;
        int     c;
        int     d;
        int     exp_delta;
        int     thresh;
        logic   exp_acc;
        int     tmp;
        int     i;
        int     j;
        next_model_move(k, l, rm, rx);
        check_equal("report.move.k", 64'(k), 64'(report.move.k));
        check_equal("report.move.l", 64'(l), 64'(report.move.l));
        check_equal("report.move.r_metropolis", 64'(rm), 64'(report.move.r_metropolis));
        check_equal("report.move.r_exchange", 64'(rx), 64'(report.move.r_exchange));

        a = tour_model[(int'(k) + CITY_NUM - 1) % CITY_NUM];
        b = tour_model[int'(k)];
        c = tour_model[int'(l)];
        d = tour_model[(int'(l) + 1) % CITY_NUM];
        exp_delta = dist_between(a, c) + dist_between(b, d)
                  - dist_between(a, b) - dist_between(c, d);
        check_equal("report.delta", 64'(delta_t'(exp_delta)), 64'(report.delta));

        thresh  = (t * int'(rm[7:0])) / 256;
        exp_acc = (exp_delta <= 0) || (exp_delta < thresh);
        check_equal("report.accepted", 64'(exp_acc), 64'(report.accepted));

        // Reverse the accepted segment in the model tour
        if (exp_acc) begin
            i = int'(k);
            j = int'(l);
            while (i < j) begin
                tmp           = tour_model[i];
                tour_model[i] = tour_model[j];
                tour_model[j] = tmp;
                i++;
                j--;
            end
        end
    endtask

    task automatic check_tour();
        logic [CITY_NUM-1:0] seen;
        seen = '0;
        for (int p = 0; p < CITY_NUM; p++) begin
            @(posedge clk);
            #2;
            rd_pos = pos_t'(p);
            @(negedge clk);
            check_equal("rd_city", 64'(tour_model[p]), 64'(rd_city));
            if (p == 0)
                check_equal("rd_city at position 0", 64'(0), 64'(rd_city));
            seen[rd_city] = 1'b1;
        end
        if (seen !== '1) begin
            errors++;
            $display("Tour readback does not hold every city exactly once");
        end
    endtask

    task automatic load_coords();
        for (int i = 0; i < CITY_NUM; i++) begin
            @(posedge clk);
            #2;
            coord_we   = 1'b1;
            coord_addr = city_t'(i);
            coord_data = coords[i];
        end
        @(posedge clk);
        #2;
        coord_we = 1'b0;
    endtask

    task automatic run_anneal(input int run_idx);
        seed_t run_seed;
        int    t;
        int    n;
        int    seen_reports;
        logic  finished;
        run_seed     = stim[RUN_BASE + 3 * run_idx];
        t            = int'(stim[RUN_BASE + 3 * run_idx + 1][7:0]);
        n            = int'(stim[RUN_BASE + 3 * run_idx + 2][15:0]);
        seen_reports = 0;
        finished     = 1'b0;
        rng          = run_seed;

        @(posedge clk);
        #2;
        start      = 1'b1;
        seed       = run_seed;
        temp       = temp_t'(t);
        move_count = count_t'(n);
        @(posedge clk);
        #2;
        start = 1'b0;
        check_equal("busy", 64'(1), 64'(busy));

        while (!finished) begin
            if (report_valid) begin
                check_report(t);
                seen_reports++;
            end
            if (done) begin
                finished = 1'b1;
            end else begin
                @(posedge clk);
                #2;
            end
        end
        reports_total += seen_reports;
        check_equal("report count", 64'(n), 64'(seen_reports));
        check_equal("busy", 64'(0), 64'(busy));

        // done is a single pulse and no report trails it
        @(posedge clk);
        #2;
        check_equal("done", 64'(0), 64'(done));
        check_equal("report_valid", 64'(0), 64'(report_valid));
        check_tour();
    endtask

    initial begin
        int total_moves;
        reset         = 1'b1;
        start         = 1'b0;
        seed          = '0;
        temp          = '0;
        move_count    = '0;
        coord_we      = 1'b0;
        coord_addr    = '0;
        coord_data    = '0;
        rd_pos        = '0;
        checks        = 0;
        errors        = 0;
        reports_total = 0;

        $readmemh("test/anneal_stimulus.txt", stim);
        num_runs = int'(stim[0][7:0]);
        for (int i = 0; i < CITY_NUM; i++) begin
            coords[i]     = xy_t'(stim[1 + i][15:0]);
            tour_model[i] = i;
        end
        total_moves = 0;
        for (int r = 0; r < num_runs; r++)
            total_moves += int'(stim[RUN_BASE + 3 * r + 2][15:0]);
        cycle_limit = total_moves * (40 + 8 * CITY_NUM) + 200;

        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        check_equal("busy", 64'(0), 64'(busy));
        check_equal("done", 64'(0), 64'(done));
        check_equal("report_valid", 64'(0), 64'(report_valid));

        load_coords();
        check_tour();
        for (int r = 0; r < num_runs; r++)
            run_anneal(r);

        $display("Checks: %0d, errors: %0d, reports: %0d", checks, errors, reports_total);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Watchdog on the cycle count
    initial begin
        cycle_count = 0;
        @(posedge clk);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the runs did not finish within %0d cycles", cycle_limit);
        $display("Some tests failed");
        $finish;
    end

endmodule
